/* Bender.yml */
package:
  name: core

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/fetch.sv
      - hdl/decode.sv
      - hdl/execute.sv
      - hdl/memwb.sv
      - hdl/core.sv
  - target: test
    files:
      - tb/core_sva.sv
      - tb/core_tb.sv

/* compile.f */
hdl/core_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memwb.sv
hdl/core.sv
tb/core_sva.sv
tb/core_tb.sv

/* hdl/core.sv */
`timescale 1ns/100ps

module core (
    input  logic                            i_clk,
    input  logic                            i_rst,
    output logic [core_pkg::RW-1:0]         o_req_addr,
    output logic                            o_req_ppl_submit,
    input  logic [core_pkg::I_SIZE-1:0]     i_req_data,
    input  logic                            i_req_data_valid,
    output logic [core_pkg::RW-1:0]         o_mem_addr,
    output logic [core_pkg::RW-1:0]         o_mem_data,
    input  logic [core_pkg::RW-1:0]         i_mem_data,
    output logic                            o_mem_req,
    output logic                            o_mem_we,
    input  logic                            i_mem_ack,
    output logic [core_pkg::ADDR_BYTES-1:0] o_mem_sel,
    output logic [core_pkg::RW-1:0]         o_dbg_r0,
    output logic [core_pkg::RW-1:0]         o_dbg_pc
);

    // ************************************************************************
    // Stage connections
    // ************************************************************************

    logic                             fd_submit, fd_ready;
    logic [core_pkg::I_SIZE-1:0]      fd_instr;
    logic                             flush;
    logic [core_pkg::RW-1:0]          exec_pc;

    logic                             de_submit, de_ready;
    logic [core_pkg::RW-1:0]          de_imm;
    logic [core_pkg::ALU_MODE_W-1:0]  de_alu_mode;
    logic [core_pkg::REGNO_LOG-1:0]   de_l_reg_sel, de_r_reg_sel;
    logic [core_pkg::REGNO-1:0]       de_rf_ie;
    logic                             de_r_bus_imm, de_flags_ie;
    logic [core_pkg::JUMP_CODE_W-1:0] de_jump_cond_code;
    logic                             de_mem_access, de_mem_we, de_mem_width;
    logic [1:0]                       de_used_operands;

    logic                             ew_submit, ew_ready;
    logic [core_pkg::RW-1:0]          ew_data, ew_addr;
    logic [core_pkg::REGNO-1:0]       ew_reg_ie;
    logic                             ew_mem_access, ew_mem_we, ew_mem_width;
    logic [core_pkg::REGNO-1:0]       wb_reg_ie;
    logic [core_pkg::RW-1:0]          wb_reg_data;

    fetch fetch_i (
        .i_clk(i_clk), .i_rst(i_rst), .o_mem_addr(o_req_addr),
        .o_mem_submit(o_req_ppl_submit), .i_mem_data(i_req_data),
        .i_mem_ack(i_req_data_valid), .i_next_ready(fd_ready), .o_submit(fd_submit),
        .o_instr(fd_instr), .i_exec_pc(exec_pc), .i_flush(flush));

    decode decode_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(fd_submit), .o_ready(fd_ready),
        .i_instr(fd_instr), .i_flush(flush), .o_submit(de_submit), .i_next_ready(de_ready),
        .o_imm(de_imm), .o_alu_mode(de_alu_mode), .o_l_reg_sel(de_l_reg_sel),
        .o_r_reg_sel(de_r_reg_sel), .o_rf_ie(de_rf_ie), .o_r_bus_imm(de_r_bus_imm),
        .o_flags_ie(de_flags_ie), .o_jump_cond_code(de_jump_cond_code),
        .o_mem_access(de_mem_access), .o_mem_we(de_mem_we), .o_mem_width(de_mem_width),
        .o_used_operands(de_used_operands));

    execute execute_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(de_submit), .o_ready(de_ready),
        .i_imm(de_imm), .i_alu_mode(de_alu_mode), .i_l_reg_sel(de_l_reg_sel),
        .i_r_reg_sel(de_r_reg_sel), .i_rf_ie(de_rf_ie), .i_r_bus_imm(de_r_bus_imm),
        .i_flags_ie(de_flags_ie), .i_jump_cond_code(de_jump_cond_code),
        .i_mem_access(de_mem_access), .i_mem_we(de_mem_we), .i_mem_width(de_mem_width),
        .i_used_operands(de_used_operands), .o_flush(flush), .o_exec_pc(exec_pc),
        .o_submit(ew_submit), .i_next_ready(ew_ready), .o_data(ew_data), .o_addr(ew_addr),
        .o_reg_ie(ew_reg_ie), .o_mem_access(ew_mem_access), .o_mem_we(ew_mem_we),
        .o_mem_width(ew_mem_width), .i_reg_ie(wb_reg_ie), .i_reg_data(wb_reg_data),
        .o_dbg_r0(o_dbg_r0), .o_dbg_pc(o_dbg_pc));

    memwb memwb_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(ew_submit), .o_ready(ew_ready),
        .i_data(ew_data), .i_addr(ew_addr), .i_reg_ie(ew_reg_ie),
        .i_mem_access(ew_mem_access), .i_mem_we(ew_mem_we), .i_mem_width(ew_mem_width),
        .o_reg_ie(wb_reg_ie), .o_reg_data(wb_reg_data), .o_mem_req(o_mem_req),
        .o_mem_addr(o_mem_addr), .o_mem_data(o_mem_data), .o_mem_we(o_mem_we),
        .o_mem_sel(o_mem_sel), .i_mem_data(i_mem_data), .i_mem_ack(i_mem_ack));

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    // ************************************************************************
    // Datapath widths
    // ************************************************************************

    localparam int RW          = 16;   // Register and data word.
    localparam int I_SIZE      = 32;   // Instruction word.
    localparam int REGNO       = 8;
    localparam int REGNO_LOG   = 3;
    localparam int ADDR_BYTES  = 2;    // Byte lanes per data word.

    // ************************************************************************
    // ALU modes
    // ************************************************************************

    localparam int ALU_MODE_W = 3;

    localparam logic [ALU_MODE_W-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_MODE_W-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_MODE_W-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_MODE_W-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_MODE_W-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_MODE_W-1:0] ALU_PASS_R = 3'd5;

    // ************************************************************************
    // Jump conditions
    // ************************************************************************

    localparam int JUMP_CODE_W = 2;

    localparam logic [JUMP_CODE_W-1:0] JMP_NEVER  = 2'd0;
    localparam logic [JUMP_CODE_W-1:0] JMP_ALWAYS = 2'd1;
    localparam logic [JUMP_CODE_W-1:0] JMP_ZERO   = 2'd2;

    // ************************************************************************
    // Opcodes, bits 3:0 of the instruction
    // ************************************************************************

    // Code 0 and the unused codes decode as no-operation.
    localparam logic [3:0] OP_ALU = 4'h1;  // Mode in bits 6:4.
    localparam logic [3:0] OP_LDI = 4'h2;
    localparam logic [3:0] OP_LD  = 4'h3;  // Bit 7 selects byte width.
    localparam logic [3:0] OP_ST  = 4'h4;  // Bit 7 selects byte width.
    localparam logic [3:0] OP_JMP = 4'h5;  // Target is the immediate.
    localparam logic [3:0] OP_JZ  = 4'h6;

endpackage

/* hdl/decode.sv */
`timescale 1ns/100ps

module decode (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_submit,
    output logic                             o_ready,
    input  logic [core_pkg::I_SIZE-1:0]      i_instr,
    input  logic                             i_flush,
    output logic                             o_submit,
    input  logic                             i_next_ready,
    output logic [core_pkg::RW-1:0]          o_imm,
    output logic [core_pkg::ALU_MODE_W-1:0]  o_alu_mode,
    output logic [core_pkg::REGNO_LOG-1:0]   o_l_reg_sel,
    output logic [core_pkg::REGNO_LOG-1:0]   o_r_reg_sel,
    output logic [core_pkg::REGNO-1:0]       o_rf_ie,
    output logic                             o_r_bus_imm,
    output logic                             o_flags_ie,
    output logic [core_pkg::JUMP_CODE_W-1:0] o_jump_cond_code,
    output logic                             o_mem_access,
    output logic                             o_mem_we,
    output logic                             o_mem_width,
    output logic [1:0]                       o_used_operands
);

    logic [core_pkg::I_SIZE-1:0] instr;
    logic [core_pkg::REGNO-1:0]  dest_onehot;

    assign o_ready = !o_submit || i_next_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_submit <= 1'b0;
        end else if (i_flush) begin
            o_submit <= 1'b0;                              // Drop held word.
        end else if (i_submit && o_ready) begin
            o_submit <= 1'b1;
        end else if (i_next_ready) begin
            o_submit <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_submit && o_ready && !i_flush)
            instr <= i_instr;
    end

    assign dest_onehot = {{(core_pkg::REGNO-1){1'b0}}, 1'b1} << instr[10:8];
    assign o_imm       = instr[31:16];
    assign o_l_reg_sel = instr[13:11];
    assign o_mem_width = instr[7];                         // 1 selects a byte.

    always_comb begin
        o_alu_mode       = core_pkg::ALU_PASS_R;
        o_r_reg_sel      = instr[10:8];
        o_rf_ie          = '0;
        o_r_bus_imm      = 1'b1;
        o_flags_ie       = 1'b0;
        o_jump_cond_code = core_pkg::JMP_NEVER;
        o_mem_access     = 1'b0;
        o_mem_we         = 1'b0;
        o_used_operands  = 2'b00;
        case (instr[3:0])
            core_pkg::OP_ALU: begin
                o_alu_mode      = instr[6:4];
                o_r_reg_sel     = instr[18:16];
                o_rf_ie         = dest_onehot;
                o_r_bus_imm     = 1'b0;
                o_flags_ie      = 1'b1;
                o_used_operands = 2'b11;
            end
            core_pkg::OP_LDI: o_rf_ie = dest_onehot;
            core_pkg::OP_LD: begin
                o_alu_mode      = core_pkg::ALU_ADD;       // Left reg plus immediate.
                o_rf_ie         = dest_onehot;
                o_mem_access    = 1'b1;
                o_used_operands = 2'b01;
            end
            core_pkg::OP_ST: begin
                o_r_bus_imm     = 1'b0;                    // Data from destination field.
                o_mem_access    = 1'b1;
                o_mem_we        = 1'b1;
                o_used_operands = 2'b11;
            end
            core_pkg::OP_JMP: o_jump_cond_code = core_pkg::JMP_ALWAYS;
            core_pkg::OP_JZ:  o_jump_cond_code = core_pkg::JMP_ZERO;
            default: ;
        endcase
    end

endmodule

/* hdl/execute.sv */
`timescale 1ns/100ps

module execute (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_submit,
    output logic                             o_ready,
    input  logic [core_pkg::RW-1:0]          i_imm,
    input  logic [core_pkg::ALU_MODE_W-1:0]  i_alu_mode,
    input  logic [core_pkg::REGNO_LOG-1:0]   i_l_reg_sel,
    input  logic [core_pkg::REGNO_LOG-1:0]   i_r_reg_sel,
    input  logic [core_pkg::REGNO-1:0]       i_rf_ie,
    input  logic                             i_r_bus_imm,
    input  logic                             i_flags_ie,
    input  logic [core_pkg::JUMP_CODE_W-1:0] i_jump_cond_code,
    input  logic                             i_mem_access,
    input  logic                             i_mem_we,
    input  logic                             i_mem_width,
    input  logic [1:0]                       i_used_operands,
    output logic                             o_flush,
    output logic [core_pkg::RW-1:0]          o_exec_pc,
    output logic                             o_submit,
    input  logic                             i_next_ready,
    output logic [core_pkg::RW-1:0]          o_data,
    output logic [core_pkg::RW-1:0]          o_addr,
    output logic [core_pkg::REGNO-1:0]       o_reg_ie,
    output logic                             o_mem_access,
    output logic                             o_mem_we,
    output logic                             o_mem_width,
    input  logic [core_pkg::REGNO-1:0]       i_reg_ie,
    input  logic [core_pkg::RW-1:0]          i_reg_data,
    output logic [core_pkg::RW-1:0]          o_dbg_r0,
    output logic [core_pkg::RW-1:0]          o_dbg_pc
);

    logic [core_pkg::RW-1:0]    rf [core_pkg::REGNO];
    logic [core_pkg::REGNO-1:0] pend;                      // Pending writebacks.
    logic                       zero;
    logic [core_pkg::RW-1:0]    pc_cnt;                    // Pc of the next item.
    logic [core_pkg::RW-1:0]    l_val, r_val, r_bus, alu_res;
    logic                       hazard, accept, taken;

    assign l_val = rf[i_l_reg_sel];
    assign r_val = rf[i_r_reg_sel];
    assign r_bus = i_r_bus_imm ? i_imm : r_val;

    assign hazard = (i_used_operands[0] && pend[i_l_reg_sel]) ||
                    (i_used_operands[1] && pend[i_r_reg_sel]) ||
                    |(pend & i_rf_ie);                     // Keep writebacks in order.
    assign o_ready = (!o_submit || i_next_ready) && !hazard && !o_flush;
    assign accept  = i_submit && o_ready;

    assign taken = (i_jump_cond_code == core_pkg::JMP_ALWAYS) ||
                   (i_jump_cond_code == core_pkg::JMP_ZERO && zero);

    always_comb begin
        case (i_alu_mode)
            core_pkg::ALU_ADD: alu_res = l_val + r_bus;
            core_pkg::ALU_SUB: alu_res = l_val - r_bus;
            core_pkg::ALU_AND: alu_res = l_val & r_bus;
            core_pkg::ALU_OR:  alu_res = l_val | r_bus;
            core_pkg::ALU_XOR: alu_res = l_val ^ r_bus;
            default:           alu_res = r_bus;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pend     <= '0;
            zero     <= 1'b0;
            pc_cnt   <= '0;
            o_flush  <= 1'b0;
            o_submit <= 1'b0;
        end else begin
            pend    <= (pend & ~i_reg_ie) | (accept ? i_rf_ie : '0);
            o_flush <= accept && taken;
            if (accept) begin
                o_submit <= 1'b1;
                pc_cnt   <= taken ? i_imm : pc_cnt + 1'b1;
                if (i_flags_ie)
                    zero <= (alu_res == '0);
            end else if (i_next_ready) begin
                o_submit <= 1'b0;
            end
        end
    end

    // Item payload.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_data       <= i_mem_we ? r_val : alu_res;
            o_addr       <= i_mem_we ? l_val : alu_res;
            o_reg_ie     <= i_rf_ie;
            o_mem_access <= i_mem_access;
            o_mem_we     <= i_mem_we;
            o_mem_width  <= i_mem_width;
            o_exec_pc    <= i_imm;                          // Jump target.
            o_dbg_pc     <= pc_cnt;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int r = 0; r < core_pkg::REGNO; r++) begin
            if (i_reg_ie[r])
                rf[r] <= i_reg_data;
        end
    end

    assign o_dbg_r0 = rf[0];

endmodule

/* hdl/fetch.sv */
`timescale 1ns/100ps

module fetch (
    input  logic                        i_clk,
    input  logic                        i_rst,
    output logic [core_pkg::RW-1:0]     o_mem_addr,
    output logic                        o_mem_submit,
    input  logic [core_pkg::I_SIZE-1:0] i_mem_data,
    input  logic                        i_mem_ack,
    input  logic                        i_next_ready,
    output logic                        o_submit,
    output logic [core_pkg::I_SIZE-1:0] o_instr,
    input  logic [core_pkg::RW-1:0]     i_exec_pc,
    input  logic                        i_flush
);

    logic [core_pkg::RW-1:0] pc;
    logic                    busy;     // Read outstanding.
    logic                    stale;    // Outstanding read belongs to the old path.

    assign o_mem_addr = pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc           <= '0;
            busy         <= 1'b0;
            stale        <= 1'b0;
            o_submit     <= 1'b0;
            o_mem_submit <= 1'b0;
        end else begin
            o_mem_submit <= 1'b0;                          // One-cycle pulse.
            if (i_mem_ack)
                busy <= 1'b0;
            if (i_flush) begin
                pc       <= i_exec_pc;
                o_submit <= 1'b0;
                stale    <= busy && !i_mem_ack;
            end else begin
                if (i_mem_ack) begin
                    if (stale)
                        stale <= 1'b0;                     // Drop old-path word.
                    else
                        o_submit <= 1'b1;
                end
                if (o_submit && i_next_ready) begin
                    o_submit <= 1'b0;
                    pc       <= pc + 1'b1;
                end
                if (!busy && (!o_submit || i_next_ready)) begin
                    o_mem_submit <= 1'b1;
                    busy         <= 1'b1;
                end
            end
        end
    end

    // Holding register for the response.
    always_ff @(posedge i_clk) begin
        if (i_mem_ack && !stale)
            o_instr <= i_mem_data;
    end

endmodule

/* hdl/memwb.sv */
`timescale 1ns/100ps

module memwb (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_submit,
    output logic                            o_ready,
    input  logic [core_pkg::RW-1:0]         i_data,
    input  logic [core_pkg::RW-1:0]         i_addr,
    input  logic [core_pkg::REGNO-1:0]      i_reg_ie,
    input  logic                            i_mem_access,
    input  logic                            i_mem_we,
    input  logic                            i_mem_width,
    output logic [core_pkg::REGNO-1:0]      o_reg_ie,
    output logic [core_pkg::RW-1:0]         o_reg_data,
    output logic                            o_mem_req,
    output logic [core_pkg::RW-1:0]         o_mem_addr,
    output logic [core_pkg::RW-1:0]         o_mem_data,
    output logic                            o_mem_we,
    output logic [core_pkg::ADDR_BYTES-1:0] o_mem_sel,
    input  logic [core_pkg::RW-1:0]         i_mem_data,
    input  logic                            i_mem_ack
);

    logic [core_pkg::REGNO-1:0] ld_ie;                     // Load destination.
    logic                       byte_acc;
    logic [7:0]                 ld_byte;

    assign o_ready = !o_mem_req;
    assign ld_byte = o_mem_addr[0] ? i_mem_data[15:8] : i_mem_data[7:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_mem_req <= 1'b0;
            o_mem_we  <= 1'b0;
            o_reg_ie  <= '0;
        end else begin
            o_reg_ie <= '0;                                // One-cycle write.
            if (o_mem_req && i_mem_ack) begin
                o_mem_req <= 1'b0;
                o_mem_we  <= 1'b0;
                o_reg_ie  <= ld_ie;
            end else if (i_submit && o_ready) begin
                if (i_mem_access) begin
                    o_mem_req <= 1'b1;
                    o_mem_we  <= i_mem_we;
                end else begin
                    o_reg_ie  <= i_reg_ie;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_mem_req && i_mem_ack)
            o_reg_data <= byte_acc ? {8'h00, ld_byte} : i_mem_data;
        else if (i_submit && o_ready && !i_mem_access)
            o_reg_data <= i_data;
        if (i_submit && o_ready && i_mem_access) begin
            o_mem_addr <= i_addr;
            o_mem_data <= i_mem_width ? {2{i_data[7:0]}} : i_data;
            o_mem_sel  <= i_mem_width ? (i_addr[0] ? 2'b10 : 2'b01) : 2'b11;
            ld_ie      <= i_reg_ie;
            byte_acc   <= i_mem_width;
        end
    end

endmodule

/* tb/core_sva.sv */
`timescale 1ns/100ps

module core_sva (
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_mem_req,
    input logic        i_mem_ack,
    input logic [15:0] i_mem_addr,
    input logic        i_req_submit,
    input logic        i_req_valid,
    input logic        i_flush
);

    logic outstanding;                                    // Instruction read in flight.
    int   fail_count;

    initial fail_count = 0;

    always_ff @(posedge i_clk) begin
        if (i_rst)
            outstanding <= 1'b0;
        else if (i_req_submit)
            outstanding <= 1'b1;
        else if (i_req_valid)
            outstanding <= 1'b0;
    end

    a_mem_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_mem_req && !i_mem_ack |=> i_mem_req && $stable(i_mem_addr))
        else begin
            $error("data request dropped or address changed before ack");
            fail_count++;
        end

    a_one_read: assert property (@(posedge i_clk) disable iff (i_rst)
        i_req_submit |-> !outstanding)
        else begin
            $error("instruction request while a read is outstanding");
            fail_count++;
        end

    a_flush_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_flush |=> !i_flush)
        else begin
            $error("flush high for two cycles");
            fail_count++;
        end

endmodule

bind core core_sva sva_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_mem_req(o_mem_req), .i_mem_ack(i_mem_ack),
    .i_mem_addr(o_mem_addr), .i_req_submit(o_req_ppl_submit),
    .i_req_valid(i_req_data_valid), .i_flush(flush));

/* tb/core_tb.sv */
`timescale 1ns/100ps

module core_tb;

    localparam int NPROG  = 6;
    localparam int MAXLEN = 20;

    logic        clk;
    logic        rst;
    logic [15:0] req_addr;
    logic        req_submit;
    logic [31:0] req_data;
    logic        req_valid;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic [15:0] mem_rdata;
    logic        mem_req;
    logic        mem_we;
    logic        mem_ack;
    logic [1:0]  mem_sel;
    logic [15:0] dbg_r0;
    logic [15:0] dbg_pc;

    // ************************************************************************
    // Program table and memories
    // ************************************************************************

    logic [31:0] prog [NPROG][MAXLEN];
    int          plen [NPROG];
    string       pname [NPROG];
    logic [15:0] exp_addr [NPROG];
    logic [15:0] exp_data [NPROG];
    logic [1:0]  exp_sel [NPROG];
    logic [15:0] exp_r0 [NPROG];
    logic [15:0] exp_pc [NPROG];

    logic [31:0] imem [256];
    logic [7:0]  dmem [256];

    integer      seed;
    logic        done;                                    // Result store seen.
    logic [15:0] rec_addr, rec_data, rec_r0;
    logic [1:0]  rec_sel;
    int          errors, errs_before, passed;
    int          settle;

    core dut_i (
        .i_clk(clk), .i_rst(rst), .o_req_addr(req_addr), .o_req_ppl_submit(req_submit),
        .i_req_data(req_data), .i_req_data_valid(req_valid), .o_mem_addr(mem_addr),
        .o_mem_data(mem_wdata), .i_mem_data(mem_rdata), .o_mem_req(mem_req),
        .o_mem_we(mem_we), .i_mem_ack(mem_ack), .o_mem_sel(mem_sel),
        .o_dbg_r0(dbg_r0), .o_dbg_pc(dbg_pc));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] enc(input logic [3:0] op, input logic [2:0] mode,
                                        input logic bsel, input logic [2:0] rd,
                                        input logic [2:0] rl, input logic [15:0] imm);
        enc = {imm, 2'b00, rl, rd, bsel, mode, op};
    endfunction

    function automatic logic [31:0] ldi(input logic [2:0] rd, input logic [15:0] imm);
        ldi = enc(core_pkg::OP_LDI, 3'd0, 1'b0, rd, 3'd0, imm);
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] mode, input logic [2:0] rd,
                                        input logic [2:0] rl, input logic [2:0] rr);
        alu = enc(core_pkg::OP_ALU, mode, 1'b0, rd, rl, {13'd0, rr});
    endfunction

    function automatic logic [31:0] ld(input logic [2:0] rd, input logic [2:0] rl,
                                       input logic bsel);
        ld = enc(core_pkg::OP_LD, 3'd0, bsel, rd, rl, 16'h0000);
    endfunction

    // Data register sits in the destination field, address register on the left.
    function automatic logic [31:0] st(input logic [2:0] rdat, input logic [2:0] radr,
                                       input logic bsel);
        st = enc(core_pkg::OP_ST, 3'd0, bsel, rdat, radr, 16'h0000);
    endfunction

    function automatic logic [31:0] jmp(input logic [3:0] op, input logic [15:0] target);
        jmp = enc(op, 3'd0, 1'b0, 3'd0, 3'd0, target);
    endfunction

    task automatic put(input int p, input logic [31:0] w);
        prog[p][plen[p]] = w;
        plen[p]++;
    endtask

    task automatic set_expect(input int p, input string name, input logic [15:0] a,
                              input logic [15:0] d, input logic [1:0] s,
                              input logic [15:0] r0);
        pname[p]    = name;
        exp_addr[p] = a;
        exp_data[p] = d;
        exp_sel[p]  = s;
        exp_r0[p]   = r0;
    endtask

    // A jump to itself parks the core after the result store.
    task automatic close_program(input int p);
        exp_pc[p] = 16'(plen[p]);
        put(p, jmp(core_pkg::OP_JMP, 16'(plen[p])));
    endtask

    task automatic alu_program(input int p, input bit spaced, input logic [15:0] a,
                               input logic [15:0] b);
        put(p, ldi(3'd7, 16'h0080));
        put(p, ldi(3'd6, 16'h0040));                      // Scratch word.
        put(p, ldi(3'd2, a));
        put(p, st(3'd2, 3'd6, 1'b0));
        put(p, ldi(3'd2, b));
        put(p, ld(3'd1, 3'd6, 1'b0));                     // Reload a, used right away.
        if (spaced) begin
            put(p, 32'h0);
            put(p, 32'h0);
        end
        put(p, alu(core_pkg::ALU_AND, 3'd0, 3'd1, 3'd2));
        put(p, alu(core_pkg::ALU_OR, 3'd3, 3'd1, 3'd2));
        put(p, alu(core_pkg::ALU_ADD, 3'd4, 3'd1, 3'd2));
        if (spaced)
            put(p, 32'h0);
        put(p, alu(core_pkg::ALU_SUB, 3'd5, 3'd4, 3'd3));
        if (spaced)
            put(p, 32'h0);
        put(p, alu(core_pkg::ALU_XOR, 3'd6, 3'd5, 3'd0));
        put(p, st(3'd6, 3'd7, 1'b0));
    endtask

    task automatic build_table;
        logic [15:0] a, b;
        a = 16'h1234;
        b = 16'h0F0F;
        for (int p = 0; p < NPROG; p++)
            plen[p] = 0;
        alu_program(0, 1'b0, a, b);
        set_expect(0, "alu back-to-back", 16'h0080, ((a + b) - (a | b)) ^ (a & b), 2'b11,
                   a & b);
        alu_program(1, 1'b1, a, b);
        set_expect(1, "alu spaced", 16'h0080, ((a + b) - (a | b)) ^ (a & b), 2'b11, a & b);
        put(2, ldi(3'd1, 16'hBEEF));
        put(2, ldi(3'd2, 16'h0010));
        put(2, st(3'd1, 3'd2, 1'b0));
        put(2, ld(3'd3, 3'd2, 1'b0));
        put(2, ldi(3'd4, 16'h0021));
        put(2, ldi(3'd5, 16'h00A5));
        put(2, st(3'd5, 3'd4, 1'b1));                     // Odd byte, upper lane.
        put(2, ld(3'd6, 3'd4, 1'b1));
        put(2, alu(core_pkg::ALU_XOR, 3'd0, 3'd3, 3'd6));
        put(2, ldi(3'd7, 16'h0081));
        put(2, st(3'd0, 3'd7, 1'b1));
        set_expect(2, "load/store", 16'h0081, {2{8'h4A}}, 2'b10, 16'hBEEF ^ 16'h00A5);
        put(3, ldi(3'd7, 16'h0080));
        put(3, ldi(3'd1, 16'h1111));
        put(3, ldi(3'd2, 16'h2222));
        put(3, jmp(core_pkg::OP_JMP, 16'd6));
        put(3, st(3'd2, 3'd7, 1'b0));                     // Skipped.
        put(3, ldi(3'd0, 16'hDEAD));                      // Skipped.
        put(3, ldi(3'd0, 16'h0042));
        put(3, st(3'd1, 3'd7, 1'b0));
        set_expect(3, "jump", 16'h0080, 16'h1111, 2'b11, 16'h0042);
        put(4, ldi(3'd7, 16'h0080));
        put(4, ldi(3'd1, 16'd5));
        put(4, ldi(3'd2, 16'd5));
        put(4, ldi(3'd3, 16'd3));
        put(4, alu(core_pkg::ALU_SUB, 3'd4, 3'd1, 3'd3)); // Nonzero.
        put(4, jmp(core_pkg::OP_JZ, 16'd12));
        put(4, ldi(3'd0, 16'd1));
        put(4, alu(core_pkg::ALU_SUB, 3'd5, 3'd1, 3'd2)); // Zero.
        put(4, jmp(core_pkg::OP_JZ, 16'd11));
        put(4, st(3'd3, 3'd7, 1'b0));
        put(4, ldi(3'd0, 16'hBAD0));
        put(4, alu(core_pkg::ALU_ADD, 3'd0, 3'd0, 3'd1));
        put(4, st(3'd0, 3'd7, 1'b0));
        set_expect(4, "jump on zero", 16'h0080, 16'd1 + 16'd5, 2'b11, 16'd1 + 16'd5);
        alu_program(5, 1'b0, a, b);
        set_expect(5, "alu rerun", 16'h0080, ((a + b) - (a | b)) ^ (a & b), 2'b11, a & b);
        for (int p = 0; p < NPROG; p++)
            close_program(p);
    endtask

    // ************************************************************************
    // Memory models
    // ************************************************************************

    always begin : imem_model
        logic [7:0] addr;
        int         lat;
        @(posedge clk);
        if (req_submit === 1'b1 && !rst) begin
            addr = req_addr[7:0];
            lat  = 1 + ($unsigned($random(seed)) % 3);
            repeat (lat - 1) @(posedge clk);
            if (!rst) begin
                #1;
                req_data  = imem[addr];
                req_valid = 1'b1;
                @(posedge clk);
                #1 req_valid = 1'b0;
            end
        end
    end

    always begin : dmem_model
        logic [7:0] wa;
        int         lat;
        @(posedge clk);
        if (mem_req === 1'b1 && !rst) begin
            #1;
            lat = 1 + ($unsigned($random(seed)) % 3);    // Drawn apart from imem.
            if (lat > 1) begin
                repeat (lat - 1) @(posedge clk);
                #1;
            end
            wa = {mem_addr[7:1], 1'b0};
            if (mem_we) begin
                if (mem_sel[0])
                    dmem[wa] = mem_wdata[7:0];
                if (mem_sel[1])
                    dmem[wa | 8'd1] = mem_wdata[15:8];
                if (mem_addr >= 16'h0080 && !done) begin
                    rec_addr = mem_addr;
                    rec_data = mem_wdata;
                    rec_sel  = mem_sel;
                    rec_r0   = dbg_r0;
                    done     = 1'b1;
                end
            end else begin
                mem_rdata = {dmem[wa | 8'd1], dmem[wa]};
            end
            mem_ack = 1'b1;
            @(posedge clk);
            #1 mem_ack = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (NPROG * 200) @(posedge clk);
        $display("Run hung: no result store within %0d cycles", NPROG * 200);
        $display("*** FAILED ***");
        $finish;
    end

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin
        rst       = 1'b1;
        req_data  = '0;
        req_valid = 1'b0;
        mem_rdata = '0;
        mem_ack   = 1'b0;
        done      = 1'b0;
        seed      = 32'h496e0018;
        errors    = 0;
        passed    = 0;
        build_table();
        for (int t = 0; t < NPROG; t++) begin
            @(posedge clk);
            #1 rst = 1'b1;
            for (int i = 0; i < 256; i++) begin
                imem[i] = (i < plen[t]) ? prog[t][i] : 32'h0;
                dmem[i] = i[7:0] ^ 8'h5A;
            end
            done = 1'b0;
            repeat (5) @(posedge clk);
            #1 rst = 1'b0;
            while (!done)
                @(posedge clk);
            settle = 0;
            while (dbg_pc !== exp_pc[t] && settle < 40) begin
                @(posedge clk);
                settle++;
            end
            errs_before = errors;
            assert (rec_addr === exp_addr[t]) else begin
                $display("ERROR %0t: %s store address %h, expected %h",
                         $time, pname[t], rec_addr, exp_addr[t]);
                errors++;
            end
            assert (rec_data === exp_data[t]) else begin
                $display("ERROR %0t: %s store data %h, expected %h",
                         $time, pname[t], rec_data, exp_data[t]);
                errors++;
            end
            assert (rec_sel === exp_sel[t]) else begin
                $display("ERROR %0t: %s byte selects %b, expected %b",
                         $time, pname[t], rec_sel, exp_sel[t]);
                errors++;
            end
            assert (rec_r0 === exp_r0[t]) else begin
                $display("ERROR %0t: %s r0 %h, expected %h",
                         $time, pname[t], rec_r0, exp_r0[t]);
                errors++;
            end
            assert (dbg_pc === exp_pc[t]) else begin
                $display("ERROR %0t: %s execute pc %h, expected %h",
                         $time, pname[t], dbg_pc, exp_pc[t]);
                errors++;
            end
            if (errors == errs_before)
                passed++;
            $display("test %0d %s: %s", t, pname[t], (errors == errs_before) ? "ok" : "mismatch");
        end
        if (dut_i.sva_i.fail_count != 0) begin
            $display("Protocol assertions failed %0d times", dut_i.sva_i.fail_count);
            errors += dut_i.sva_i.fail_count;
        end
        $display("%0d of %0d tests ok, %0d check errors", passed, NPROG, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
